//--- files.f
rv_isa_pkg.sv
mem_stage_pkg.sv
stage_reg.sv
mem_access_ctrl.sv
data_ram.sv
load_align.sv
mem_stage.sv
tb_mem_checks.sv
tb_mem_stage.sv

//--- Bender.yml
package:
  name: mem_stage

sources:
  - rv_isa_pkg.sv
  - mem_stage_pkg.sv
  - stage_reg.sv
  - mem_access_ctrl.sv
  - data_ram.sv
  - load_align.sv
  - mem_stage.sv
  - target: test
    files:
      - tb_mem_checks.sv
      - tb_mem_stage.sv

//--- tb_mem_stage.sv
`default_nettype none

module tb_mem_stage;
    import rv_isa_pkg::*;
    import mem_stage_pkg::*;

    localparam int unsigned DMEM_WORDS = 256;
    localparam int unsigned TIMEOUT = 1000;         // Cycles per wait
    localparam logic [6:0] OPC_OP = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;

    logic        clk;
    logic        rst_n;
    ex_mem_t     in_data;
    logic        in_valid;
    logic        in_ready;
    mem_wb_t     out_data;
    logic        out_valid;
    logic        out_ready;
    logic        check_fail;
    int unsigned pending;
    logic        random_stalls;
    xlen_t       next_pc;

    mem_stage #(
        .DMEM_WORDS(DMEM_WORDS)
    ) u_dut (
        .clk         (clk),
        .rst_n_i     (rst_n),
        .in_i        (in_data),
        .in_valid_i  (in_valid),
        .in_ready_o  (in_ready),
        .out_o       (out_data),
        .out_valid_o (out_valid),
        .out_ready_i (out_ready)
    );

    tb_mem_checks #(
        .DMEM_WORDS(DMEM_WORDS)
    ) u_checks (
        .clk         (clk),
        .rst_n_i     (rst_n),
        .dut_in_i    (in_data),
        .in_valid_i  (in_valid),
        .in_ready_i  (in_ready),
        .out_data_i  (out_data),
        .out_valid_i (out_valid),
        .out_ready_i (out_ready),
        .fail_o      (check_fail),
        .pending_o   (pending)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge check_fail) begin
        $display("Simulation failed");
        $fatal(1, "checker reported a mismatch");
    end

    // Write-back side, stalls at random when enabled
    initial begin
        forever begin
            @(posedge clk);
            #1;
            out_ready = !random_stalls || ($urandom_range(0, 3) != 0);
        end
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Simulation failed");
        $fatal(1, "run aborted");
    endtask

    function automatic ex_mem_t make_item(input logic [6:0] opc, input logic [2:0] f3,
                                          input xlen_t result, input xlen_t rs2);
        ex_mem_t it;
        it.pc = next_pc;
        next_pc = next_pc + 4;
        it.inst = $urandom();
        it.inst[14:12] = f3;
        it.inst[6:0] = opc;
        it.rd_addr = it.inst[11:7];
        it.result = result;
        it.rs2_data = rs2;
        return it;
    endfunction

    // Holds the item until in_ready_o is seen at an edge
    task automatic send_item(input ex_mem_t item);
        int unsigned waited;
        waited = 0;
        in_data = item;
        in_valid = 1'b1;
        do begin
            @(posedge clk);
            waited++;
            if (waited > TIMEOUT) begin
                abort_run("timeout waiting for in_ready_o");
            end
        end while (!in_ready);
        #1;
        in_valid = 1'b0;
    endtask

    task automatic issue(input logic [6:0] opc, input logic [2:0] f3, input xlen_t addr,
                         input xlen_t rs2);
        send_item(make_item(opc, f3, addr, rs2));
    endtask

    task automatic wait_drained();
        int unsigned waited;
        waited = 0;
        while (pending != 0) begin
            @(posedge clk);
            #1;
            waited++;
            if (waited > TIMEOUT) begin
                abort_run("timeout waiting for the pipeline to drain");
            end
        end
    endtask

    // One aligned access or ALU op inside a word window
    task automatic random_access(input xlen_t base, input int unsigned words);
        int unsigned pick;
        int unsigned sz;
        logic [2:0]  f3;
        xlen_t       addr;
        pick = $urandom_range(0, 9);
        sz = $urandom_range(0, 2);
        f3 = 3'(sz);
        addr = base + 4 * $urandom_range(0, words - 1);
        if (sz == 0) begin
            addr = addr + $urandom_range(0, 3);
        end else if (sz == 1) begin
            addr = addr + 2 * $urandom_range(0, 1);
        end
        if (pick < 2) begin
            issue(OPC_OP, f3, $urandom(), $urandom());
        end else if (pick < 6) begin
            issue(OPC_STORE, f3, addr, $urandom());
        end else begin
            if (sz != 2) begin
                f3[2] = 1'($urandom_range(0, 1));   // LBU or LHU
            end
            issue(OPC_LOAD, f3, addr, $urandom());
        end
    endtask

    initial begin
        xlen_t v;
        void'($urandom(82));
        rst_n = 1'b0;
        in_data = '0;
        in_valid = 1'b0;
        out_ready = 1'b1;
        random_stalls = 1'b0;
        next_pc = 32'h0000_1000;
        repeat (10) @(posedge clk);
        #1;
        rst_n = 1'b1;
        repeat (3) @(posedge clk);      // Idle state is checked here
        #1;

        for (int i = 0; i < 4; i++) begin
            issue((i % 2 != 0) ? OPC_OP : OPC_OP_IMM, 3'(i), $urandom(), $urandom());
        end

        // Whole words, read back in reverse order
        for (int i = 0; i < 8; i++) begin
            issue(OPC_STORE, F3_W, 32'h20 + 4 * i, $urandom());
        end
        for (int i = 7; i >= 0; i--) begin
            issue(OPC_LOAD, F3_W, 32'h20 + 4 * i, '0);
        end

        // Byte and half merges into known words
        issue(OPC_STORE, F3_W, 32'h40, 32'h0123_4567);
        issue(OPC_STORE, F3_W, 32'h44, 32'h89ab_cdef);
        for (int i = 0; i < 4; i++) begin
            v = $urandom();
            v[7] = i[0];
            issue(OPC_STORE, F3_B, 32'h40 + i, v);
        end
        for (int i = 0; i < 4; i++) begin
            issue(OPC_LOAD, F3_B, 32'h40 + i, '0);
            issue(OPC_LOAD, F3_BU, 32'h40 + i, '0);
        end
        for (int i = 0; i < 2; i++) begin
            v = $urandom();
            v[15] = i[0];
            issue(OPC_STORE, F3_H, 32'h44 + 2 * i, v);
        end
        for (int i = 0; i < 2; i++) begin
            issue(OPC_LOAD, F3_H, 32'h44 + 2 * i, '0);
            issue(OPC_LOAD, F3_HU, 32'h44 + 2 * i, '0);
        end
        issue(OPC_LOAD, F3_W, 32'h40, '0);
        issue(OPC_LOAD, F3_W, 32'h44, '0);
        wait_drained();

        // Random traffic under back-pressure, window written first
        random_stalls = 1'b1;
        for (int i = 0; i < 16; i++) begin
            issue(OPC_STORE, F3_W, 32'h100 + 4 * i, $urandom());
        end
        for (int i = 0; i < 200; i++) begin
            random_access(32'h100, 16);
        end
        wait_drained();
        random_stalls = 1'b0;
        @(posedge clk);
        #1;

        // Back to back with the output always ready
        for (int i = 0; i < 20; i++) begin
            issue((i % 3 == 0) ? OPC_OP : OPC_LOAD, F3_W, 32'h100 + 4 * (i % 16), '0);
        end
        wait_drained();

        if (check_fail) begin
            $display("Simulation failed");
            $fatal(1, "checks failed");
        end else begin
            $display("Simulation passed");
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- tb_mem_checks.sv
`default_nettype none

module tb_mem_checks #(
    parameter int unsigned DMEM_WORDS = 256
) (
    input  logic                   clk,
    input  logic                   rst_n_i,
    // Observed DUT ports
    input  mem_stage_pkg::ex_mem_t dut_in_i,
    input  logic                   in_valid_i,
    input  logic                   in_ready_i,
    input  mem_stage_pkg::mem_wb_t out_data_i,
    input  logic                   out_valid_i,
    input  logic                   out_ready_i,
    // To the testbench top
    output logic                   fail_o,
    output int unsigned            pending_o
);
    import rv_isa_pkg::*;
    import mem_stage_pkg::*;

    logic [7:0] model [DMEM_WORDS*4];   // Byte-wide image of the data RAM
    mem_wb_t    exp_q[$];
    mem_wb_t    exp_head;
    mem_wb_t    exp_new;
    logic       seen_input = 1'b0;

    initial fail_o = 1'b0;

    task automatic flag_failure(input string msg);
        $display("%s", msg);
        fail_o = 1'b1;
    endtask

    // Write-back value of one item, stores update the model
    function automatic xlen_t model_access(input ex_mem_t it);
        logic [6:0]  opc;
        logic [2:0]  f3;
        int unsigned a;
        int unsigned nbytes;
        xlen_t       val;
        opc = it.inst[6:0];
        f3 = it.inst[14:12];
        a = it.result % (DMEM_WORDS * 4);
        nbytes = 1 << f3[1:0];
        val = it.result;
        if (opc == OPC_STORE) begin
            for (int b = 0; b < nbytes; b++) begin
                model[a+b] = it.rs2_data[8*b +: 8];     // Little endian
            end
        end else if (opc == OPC_LOAD) begin
            val = '0;
            for (int b = 0; b < nbytes; b++) begin
                val[8*b +: 8] = model[a+b];
            end
            // Signed narrow loads copy the top loaded bit upward
            if (!f3[2] && nbytes < 4 && val[8*nbytes-1]) begin
                val = val | ~((xlen_t'(1) << (8 * nbytes)) - 1);
            end
        end
        return val;
    endfunction

    always @(posedge clk) begin
        if (!rst_n_i) begin
            exp_q.delete();
            seen_input = 1'b0;
        end else begin
            if (out_valid_i && out_ready_i && exp_q.size() != 0) begin
                void'(exp_q.pop_front());
            end
            if (in_valid_i && in_ready_i) begin
                seen_input = 1'b1;
                exp_new.pc = dut_in_i.pc;
                exp_new.inst = dut_in_i.inst;
                exp_new.rd_addr = dut_in_i.rd_addr;
                exp_new.wb_data = model_access(dut_in_i);
                exp_q.push_back(exp_new);
            end
        end
        pending_o = exp_q.size();
        exp_head = (exp_q.size() != 0) ? exp_q[0] : '0;
    end

    a_idle_after_reset: assert property (@(posedge clk) disable iff (!rst_n_i)
        !seen_input |-> !out_valid_i && in_ready_i)
    else flag_failure($sformatf("error: out_valid_o %h in_ready_o %h before any input",
                                $sampled(out_valid_i), $sampled(in_ready_i)));

    a_nothing_extra: assert property (@(posedge clk) disable iff (!rst_n_i)
        out_valid_i && out_ready_i |-> pending_o != 0)
    else flag_failure("error: output transfer with no item outstanding");

    // Order check on pc first, then the whole item
    a_order: assert property (@(posedge clk) disable iff (!rst_n_i)
        out_valid_i && out_ready_i |-> out_data_i.pc === exp_head.pc)
    else flag_failure($sformatf("error: out_o.pc got %h expected %h",
                                $sampled(out_data_i.pc), $sampled(exp_head.pc)));

    a_item: assert property (@(posedge clk) disable iff (!rst_n_i)
        out_valid_i && out_ready_i |-> out_data_i === exp_head)
    else flag_failure($sformatf("error: out_o got %h expected %h",
                                $sampled(out_data_i), $sampled(exp_head)));

    a_stall_hold: assert property (@(posedge clk) disable iff (!rst_n_i)
        out_valid_i && !out_ready_i |=> out_valid_i && $stable(out_data_i))
    else flag_failure($sformatf("error: out_o got %h while stalled, held %h",
                                $sampled(out_data_i), $past(out_data_i)));

    a_latency: assert property (@(posedge clk) disable iff (!rst_n_i)
        $past(in_valid_i && in_ready_i, 2) && $past(out_ready_i) |->
            out_valid_i && out_data_i.pc == $past(dut_in_i.pc, 2))
    else flag_failure($sformatf("error: out_o.pc got %h expected %h two cycles after input",
                                $sampled(out_data_i.pc), $past(dut_in_i.pc, 2)));

    a_throughput: assert property (@(posedge clk) disable iff (!rst_n_i)
        out_ready_i |-> in_ready_i)
    else flag_failure($sformatf("error: in_ready_o got %h expected 1 with out_ready_i high",
                                $sampled(in_ready_i)));

endmodule

`default_nettype wire

//--- mem_stage.sv
`default_nettype none

module mem_stage #(
    parameter int unsigned DMEM_WORDS = 256
) (
    input  logic                   clk,
    input  logic                   rst_n_i,
    // From execute
    input  mem_stage_pkg::ex_mem_t in_i,
    input  logic                   in_valid_i,
    output logic                   in_ready_o,
    // To write-back
    output mem_stage_pkg::mem_wb_t out_o,
    output logic                   out_valid_o,
    input  logic                   out_ready_i
);
    import mem_stage_pkg::*;

    ex_mem_t   cur_item;
    logic      cur_valid;
    logic      cur_ready;
    mem_pend_t pend_d;
    logic      pend_valid;
    logic      pend_ready;
    mem_pend_t pend_q;
    logic      ram_en;
    dmem_req_t ram_req;
    xlen_t     ram_rdata;

    stage_reg #(
        .T(ex_mem_t)
    ) u_in_reg (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .valid_i (in_valid_i),
        .ready_o (in_ready_o),
        .data_i  (in_i),
        .valid_o (cur_valid),
        .ready_i (cur_ready),
        .data_o  (cur_item)
    );

    mem_access_ctrl #(
        .DMEM_WORDS(DMEM_WORDS)
    ) u_ctrl (
        .item_i       (cur_item),
        .item_valid_i (cur_valid),
        .item_ready_o (cur_ready),
        .pend_o       (pend_d),
        .pend_valid_o (pend_valid),
        .pend_ready_i (pend_ready),
        .ram_en_o     (ram_en),
        .req_o        (ram_req)
    );

    // Read word lands together with its item in u_out_reg
    data_ram #(
        .DMEM_WORDS(DMEM_WORDS)
    ) u_ram (
        .clk     (clk),
        .en_i    (ram_en),
        .req_i   (ram_req),
        .rdata_o (ram_rdata)
    );

    stage_reg #(
        .T(mem_pend_t)
    ) u_out_reg (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .valid_i (pend_valid),
        .ready_o (pend_ready),
        .data_i  (pend_d),
        .valid_o (out_valid_o),
        .ready_i (out_ready_i),
        .data_o  (pend_q)
    );

    load_align u_align (
        .pend_i  (pend_q),
        .rdata_i (ram_rdata),
        .wb_o    (out_o)
    );

endmodule

`default_nettype wire

//--- load_align.sv
`default_nettype none

module load_align (
    input  mem_stage_pkg::mem_pend_t pend_i,
    input  mem_stage_pkg::xlen_t     rdata_i,
    output mem_stage_pkg::mem_wb_t   wb_o
);
    import rv_isa_pkg::*;
    import mem_stage_pkg::*;

    logic [7:0]  lane_b;
    logic [15:0] lane_h;
    logic        fill_b;
    logic        fill_h;
    xlen_t       load_val;

    // Pick the addressed byte and half out of the read word
    assign lane_b = rdata_i[{pend_i.offset, 3'b000} +: 8];
    assign lane_h = rdata_i[{pend_i.offset[1], 4'b0000} +: 16];

    assign fill_b = pend_i.sext && lane_b[7];   // Sign bit or zero
    assign fill_h = pend_i.sext && lane_h[15];

    always_comb begin
        case (pend_i.size)
            BYTE:    load_val = {{(XLEN-8){fill_b}}, lane_b};
            HALF:    load_val = {{(XLEN-16){fill_h}}, lane_h};
            default: load_val = rdata_i;
        endcase
    end

    // Stores and ALU ops write back the execute result
    assign wb_o = '{
        pc:      pend_i.pc,
        inst:    pend_i.inst,
        rd_addr: pend_i.rd_addr,
        wb_data: (pend_i.kind == LOAD) ? load_val : pend_i.result
    };

endmodule

`default_nettype wire

//--- data_ram.sv
`default_nettype none

module data_ram #(
    parameter int unsigned DMEM_WORDS = 256
) (
    input  logic                     clk,
    input  logic                     en_i,
    input  mem_stage_pkg::dmem_req_t req_i,
    output mem_stage_pkg::xlen_t     rdata_o
);
    import mem_stage_pkg::*;

    localparam int unsigned IDX_W = (DMEM_WORDS > 1) ? $clog2(DMEM_WORDS) : 1;

    xlen_t             mem [DMEM_WORDS];   // Contents are not reset
    xlen_t             rdata_q;
    logic [IDX_W-1:0]  idx;

    assign idx = req_i.widx[IDX_W-1:0];

    // Per-lane writes under the byte mask
    always_ff @(posedge clk) begin
        if (en_i && req_i.we) begin
            for (int lane = 0; lane < NUM_LANES; lane++) begin
                if (req_i.wmask[lane]) begin
                    mem[idx][lane*8 +: 8] <= req_i.wdata[lane*8 +: 8];
                end
            end
        end
    end

    // Old word is returned, read before write
    always_ff @(posedge clk) begin
        if (en_i) begin
            rdata_q <= mem[idx];
        end
    end

    assign rdata_o = rdata_q;

    // Upper index bits are dropped above, so they must be zero on access
    property p_index_in_range;
        @(posedge clk) en_i |-> (req_i.widx < DMEM_WORDS);
    endproperty

    a_index_in_range: assert property (p_index_in_range)
    else $error("data_ram: word index %0d out of range", req_i.widx);

endmodule

`default_nettype wire

//--- mem_access_ctrl.sv
`default_nettype none

module mem_access_ctrl #(
    parameter int unsigned DMEM_WORDS = 256
) (
    input  mem_stage_pkg::ex_mem_t   item_i,
    input  logic                     item_valid_i,
    output logic                     item_ready_o,
    output mem_stage_pkg::mem_pend_t pend_o,
    output logic                     pend_valid_o,
    input  logic                     pend_ready_i,
    output logic                     ram_en_o,
    output mem_stage_pkg::dmem_req_t req_o
);
    import rv_isa_pkg::*;
    import mem_stage_pkg::*;

    localparam int unsigned IDX_W = (DMEM_WORDS > 1) ? $clog2(DMEM_WORDS) : 1;

    opcode_t          opcode;
    funct3_t          funct3;
    logic             f3_ok;
    mem_kind_e        kind;
    mem_size_e        size;
    logic             sext;
    logic [OFF_W-1:0] offset;
    logic             xfer;

    assign opcode = inst_opcode(item_i.inst);
    assign funct3 = inst_funct3(item_i.inst);
    assign offset = item_i.result[OFF_W-1:0];

    // Width and signedness from funct3
    always_comb begin
        size = WORD;
        sext = 1'b0;
        f3_ok = 1'b1;
        case (funct3)
            F3_B: begin
                size = BYTE;
                sext = 1'b1;
            end
            F3_H: begin
                size = HALF;
                sext = 1'b1;
            end
            F3_W:  size = WORD;
            F3_BU: size = BYTE;
            F3_HU: size = HALF;
            default: f3_ok = 1'b0;
        endcase
    end

    always_comb begin
        kind = NONE;
        if (opcode == OPC_LOAD && f3_ok) begin
            kind = LOAD;
        end else if (opcode == OPC_STORE && f3_ok && !funct3[2]) begin
            kind = STORE;   // No unsigned stores
        end
    end

    // Valid/ready pass straight through, the RAM rides on the transfer
    assign pend_valid_o = item_valid_i;
    assign item_ready_o = pend_ready_i;
    assign xfer = item_valid_i && pend_ready_i;
    assign ram_en_o = xfer && (kind != NONE);

    always_comb begin
        req_o.widx = '0;
        req_o.widx[IDX_W-1:0] = item_i.result[IDX_W+OFF_W-1:OFF_W];
        req_o.we = (kind == STORE);
        req_o.wmask = '0;
        req_o.wdata = item_i.rs2_data;
        if (kind == STORE) begin
            case (size)
                BYTE: begin
                    req_o.wmask = byte_mask_t'(1) << offset;
                    req_o.wdata = xlen_t'(item_i.rs2_data[7:0]) << {offset, 3'b000};
                end
                HALF: begin
                    req_o.wmask = byte_mask_t'(2'b11) << {offset[1], 1'b0};
                    req_o.wdata = xlen_t'(item_i.rs2_data[15:0]) << {offset[1], 4'b0000};
                end
                default: req_o.wmask = '1;  // Whole word
            endcase
        end
    end

    assign pend_o = '{
        pc:      item_i.pc,
        inst:    item_i.inst,
        rd_addr: item_i.rd_addr,
        result:  item_i.result,
        kind:    kind,
        size:    size,
        sext:    sext,
        offset:  offset
    };

    // Misaligned accesses are not trapped, only flagged here
    a_aligned: assert final (!ram_en_o || size == BYTE ||
                             (size == HALF && !offset[0]) ||
                             (size == WORD && offset == '0))
    else $error("mem_access_ctrl: misaligned access at %h", item_i.result);

    a_mask_on_write: assert final (!(ram_en_o && req_o.we) || req_o.wmask != '0)
    else $error("mem_access_ctrl: store with empty byte mask");

endmodule

`default_nettype wire

//--- stage_reg.sv
`default_nettype none

module stage_reg #(
    parameter type T = logic
) (
    input  logic clk,
    input  logic rst_n_i,
    // Upstream side
    input  logic valid_i,
    output logic ready_o,
    input  T     data_i,
    // Downstream side
    output logic valid_o,
    input  logic ready_i,
    output T     data_o
);

    logic valid_q;
    T     data_q;
    logic load;

    // Accept when empty or when the held item leaves this cycle
    assign ready_o = !valid_q || ready_i;
    assign load = valid_i && ready_o;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            valid_q <= 1'b0;
        end else if (ready_o) begin
            valid_q <= valid_i;     // Refill or drain
        end
    end

    // Payload is loaded only on a transfer
    always_ff @(posedge clk) begin
        if (load) begin
            data_q <= data_i;
        end
    end

    assign valid_o = valid_q;
    assign data_o = data_q;

    // A stalled item must stay put until the consumer takes it
    property p_hold_when_stalled;
        @(posedge clk) disable iff (!rst_n_i)
        valid_o && !ready_i |=> valid_o && $stable(data_o);
    endproperty

    a_hold_when_stalled: assert property (p_hold_when_stalled)
    else $error("stage_reg: payload changed while stalled");

endmodule

`default_nettype wire

//--- mem_stage_pkg.sv
`default_nettype none

package mem_stage_pkg;

    localparam int XLEN = 32;
    localparam int REG_ADDR_W = 5;
    localparam int NUM_LANES = XLEN / 8;            // Byte lanes per word
    localparam int OFF_W = $clog2(NUM_LANES);       // Byte offset bits
    localparam int WIDX_W = XLEN - OFF_W;           // Word index bits

    typedef logic [XLEN-1:0] xlen_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [NUM_LANES-1:0] byte_mask_t;

    // Item handed over by the execute stage
    typedef struct packed {
        xlen_t     pc;
        xlen_t     inst;
        xlen_t     result;      // ALU result, also the load/store address
        xlen_t     rs2_data;
        reg_addr_t rd_addr;
    } ex_mem_t;

    // Item waiting on the RAM read, decode already done
    typedef struct packed {
        xlen_t                 pc;
        xlen_t                 inst;
        reg_addr_t             rd_addr;
        xlen_t                 result;
        rv_isa_pkg::mem_kind_e kind;
        rv_isa_pkg::mem_size_e size;
        logic                  sext;
        logic [OFF_W-1:0]      offset;
    } mem_pend_t;

    typedef struct packed {
        xlen_t     pc;
        xlen_t     inst;
        reg_addr_t rd_addr;
        xlen_t     wb_data;
    } mem_wb_t;

    typedef struct packed {
        logic [WIDX_W-1:0] widx;
        logic              we;
        byte_mask_t        wmask;
        xlen_t             wdata;   // Already shifted into its lanes
    } dmem_req_t;

endpackage

`default_nettype wire

//--- rv_isa_pkg.sv
`default_nettype none

package rv_isa_pkg;

    localparam int ILEN = 32;       // Base instruction length
    localparam int OPCODE_BITS = 7;
    localparam int FUNCT3_BITS = 3;
    localparam int FUNCT3_LSB = 12;

    typedef logic [OPCODE_BITS-1:0] opcode_t;
    typedef logic [FUNCT3_BITS-1:0] funct3_t;

    // Major opcodes for memory instructions
    localparam opcode_t OPC_LOAD  = 7'b0000011;
    localparam opcode_t OPC_STORE = 7'b0100011;

    // Width and signedness codes, shared by loads and stores
    localparam funct3_t F3_B  = 3'b000;
    localparam funct3_t F3_H  = 3'b001;
    localparam funct3_t F3_W  = 3'b010;
    localparam funct3_t F3_BU = 3'b100;     // Load only
    localparam funct3_t F3_HU = 3'b101;     // Load only

    typedef enum logic [1:0] {
        NONE,
        LOAD,
        STORE
    } mem_kind_e;

    typedef enum logic [1:0] {
        BYTE,
        HALF,
        WORD
    } mem_size_e;

    function automatic opcode_t inst_opcode(input logic [ILEN-1:0] inst);
        return inst[OPCODE_BITS-1:0];
    endfunction

    function automatic funct3_t inst_funct3(input logic [ILEN-1:0] inst);
        return inst[FUNCT3_LSB +: FUNCT3_BITS];
    endfunction

endpackage

`default_nettype wire
